//--- src.f
design/seq_pkg.sv
design/lamp_pkg.sv
design/tick_timer.sv
design/turn_sequencer.sv
design/lamp_encoder.sv
design/taillight_top.sv
verif/tb_taillight.sv

//--- run_sim.sh
#!/bin/sh
# build the taillight testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_taillight -o tb_taillight \
    && ./obj_dir/tb_taillight | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

//--- verif/tb_taillight.sv
module tb_taillight;

    timeunit 1ns;
    timeprecision 1ps;

    // six phases of at most 200 cycles each, with some margin
    localparam int TIMEOUT_CYCLES = 1500;

    logic clk = 1'b0;
    logic rst;
    logic l;
    logic r;
    logic brake;
    logic la;
    logic lb;
    logic lc;
    logic ra;
    logic rb;
    logic rc;

    // ####################
    // reference model state

    logic [seq_pkg::TICK_BITS-1:0] m_count;  // mirror of the step counter
    seq_pkg::seq_state_t           m_state_l;
    seq_pkg::seq_state_t           m_state_r;
    lamp_pkg::lamp_t               exp_left;   // expected registered lamps
    lamp_pkg::lamp_t               exp_right;
    lamp_pkg::lamp_t               act_left;
    lamp_pkg::lamp_t               act_right;

    int          error_count = 0;
    int          cycle_count = 0;
    int unsigned seed;

    logic check_dark_right;   // phase 2, right side must stay off
    logic check_hazard;       // phase 4, both sides identical
    logic check_brake_right;  // phase 5, idle right side fully lit

    assign act_left  = {lc, lb, la};  // c is outer, bit 2
    assign act_right = {rc, rb, ra};

    taillight_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .l     (l),
        .r     (r),
        .brake (brake),
        .la    (la),
        .lb    (lb),
        .lc    (lc),
        .ra    (ra),
        .rb    (rb),
        .rc    (rc)
    );

    always #50 clk = ~clk;  // 100 ns period

    // ####################
    // helpers

    // plain 32-bit LCG, upper bits are the useful ones
    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // sweep rule, request only matters while idle
    function automatic seq_pkg::seq_state_t next_sweep(input seq_pkg::seq_state_t s,
                                                       input logic req);
        case (s)
            seq_pkg::SEQ_IDLE:  return req ? seq_pkg::SEQ_ONE : seq_pkg::SEQ_IDLE;
            seq_pkg::SEQ_ONE:   return seq_pkg::SEQ_TWO;
            seq_pkg::SEQ_TWO:   return seq_pkg::SEQ_THREE;
            default:            return seq_pkg::SEQ_IDLE;  // three wraps to dark
        endcase
    endfunction

    // lamps for one side given its state and brake
    function automatic lamp_pkg::lamp_t expected_lamps(input seq_pkg::seq_state_t s,
                                                       input logic brk);
        case (s)
            seq_pkg::SEQ_ONE:   return 3'b001;  // inner only
            seq_pkg::SEQ_TWO:   return 3'b011;
            seq_pkg::SEQ_THREE: return 3'b111;
            default:            return brk ? 3'b111 : 3'b000;
        endcase
    endfunction

    task automatic check_lamps(input string name, input lamp_pkg::lamp_t expected,
                               input lamp_pkg::lamp_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0d ns: %s expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic hold_cycles(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    // ####################
    // model update and compare

    always @(posedge clk) begin
        if (rst) begin
            m_count   = '0;
            m_state_l = seq_pkg::SEQ_IDLE;
            m_state_r = seq_pkg::SEQ_IDLE;
            exp_left  = '0;
            exp_right = '0;
        end else begin
            // encoder register sees the state from before this edge
            exp_left  = expected_lamps(m_state_l, brake);
            exp_right = expected_lamps(m_state_r, brake);
            if (m_count == '1) begin  // tick cycle
                m_state_l = next_sweep(m_state_l, l);
                m_state_r = next_sweep(m_state_r, r);
            end
            m_count = m_count + 1'b1;
        end
        #1;  // let the DUT registers settle
        check_lamps("{lc,lb,la}", exp_left, act_left);
        check_lamps("{rc,rb,ra}", exp_right, act_right);
        if (check_dark_right) begin
            check_lamps("{rc,rb,ra} dark", lamp_pkg::LAMPS_OFF, act_right);
        end
        if (check_hazard) begin
            check_lamps("{rc,rb,ra} vs left", exp_left, act_right);
        end
        if (check_brake_right) begin
            check_lamps("{rc,rb,ra} brake", lamp_pkg::LAMPS_ON, act_right);
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", error_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ####################
    // stimulus

    initial begin
        rst               = 1'b1;
        l                 = 1'b0;
        r                 = 1'b0;
        brake             = 1'b0;
        seed              = 32'd88;
        check_dark_right  = 1'b0;
        check_hazard      = 1'b0;
        check_brake_right = 1'b0;

        // phase 1, reset then quiet, all lamps off
        hold_cycles(2);
        rst = 1'b0;
        hold_cycles(8);

        // phase 2, a 4 cycle pulse spans exactly one tick
        check_dark_right = 1'b1;
        l = 1'b1;
        hold_cycles(4);
        l = 1'b0;
        hold_cycles(20);
        check_dark_right = 1'b0;

        // phase 3, held right request, then drop it mid sweep
        r = 1'b1;
        hold_cycles(40);
        while (m_state_r != seq_pkg::SEQ_TWO) begin
            @(negedge clk);
        end
        r = 1'b0;  // sweep must still run to three and back
        hold_cycles(20);

        // phase 4, hazard, both sides idle so both start on one tick
        check_hazard = 1'b1;
        l = 1'b1;
        r = 1'b1;
        hold_cycles(40);
        l = 1'b0;
        r = 1'b0;
        hold_cycles(20);
        check_hazard = 1'b0;

        // phase 5, brake while the left side sweeps
        l = 1'b1;
        while (m_state_l == seq_pkg::SEQ_IDLE) begin
            @(negedge clk);
        end
        l     = 1'b0;
        brake = 1'b1;
        hold_cycles(1);  // brake is registered by now
        check_brake_right = 1'b1;
        hold_cycles(24);  // left finishes and goes to all on
        brake             = 1'b0;
        check_brake_right = 1'b0;
        hold_cycles(4);

        // phase 6, random levels and hold lengths
        repeat (8) begin
            seed  = lcg_next(seed);
            l     = seed[16];
            r     = seed[19];
            brake = seed[22];
            seed  = lcg_next(seed);
            hold_cycles(1 + (seed >> 16) % 32'd20);
        end
        l     = 1'b0;
        r     = 1'b0;
        brake = 1'b0;
        hold_cycles(20);

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- design/taillight_top.sv
module taillight_top (
    input  logic clk,
    input  logic rst,
    input  logic l,     // left turn request level
    input  logic r,     // right turn request level
    input  logic brake, // brake pedal level
    output logic la,    // left inner
    output logic lb,    // left middle
    output logic lc,    // left outer
    output logic ra,    // right inner
    output logic rb,    // right middle
    output logic rc     // right outer
);

    logic                step_tick;   // shared by both sides
    seq_pkg::seq_state_t state_left;
    seq_pkg::seq_state_t state_right;
    lamp_pkg::lamp_t     lamps_left;
    lamp_pkg::lamp_t     lamps_right;

    // ####################
    // step timer

    // one timer for both sides, both requests held start on the same tick
    tick_timer u_tick (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick)
    );

    // ####################
    // sequencers

    // independent machines, one side never waits on the other
    turn_sequencer u_seq_left (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick),
        .request   (l),
        .state     (state_left)
    );

    turn_sequencer u_seq_right (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick),
        .request   (r),
        .state     (state_right)
    );

    // ####################
    // encoders

    lamp_encoder u_enc_left (
        .clk   (clk),
        .rst   (rst),
        .state (state_left),
        .brake (brake),
        .lamps (lamps_left)
    );

    lamp_encoder u_enc_right (
        .clk   (clk),
        .rst   (rst),
        .state (state_right),
        .brake (brake),
        .lamps (lamps_right)
    );

    // pin split, a is inner (bit 0) and c is outer (bit 2) on both sides
    assign la = lamps_left[0];
    assign lb = lamps_left[1];
    assign lc = lamps_left[2];
    assign ra = lamps_right[0];
    assign rb = lamps_right[1];
    assign rc = lamps_right[2];

endmodule

//--- design/lamp_encoder.sv
module lamp_encoder (
    input  logic                clk,
    input  logic                rst,
    input  seq_pkg::seq_state_t state,
    input  logic                brake,
    output lamp_pkg::lamp_t     lamps
);

    // pattern before the output register
    lamp_pkg::lamp_t pattern;

    // ####################
    // state to lamps

    always_comb begin
        if (state == seq_pkg::SEQ_IDLE) begin
            // brake only owns a side that is not sweeping
            pattern = brake ? lamp_pkg::LAMPS_ON : lamp_pkg::LAMPS_OFF;
        end else begin
            // thermometer, state n lights the lowest n lamps
            pattern = lamp_pkg::lamp_t'((1 << state) - 1);
        end
    end

    // ####################
    // output register

    // state and brake are sampled on the same edge
    // lamps trail the state by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lamps <= lamp_pkg::LAMPS_OFF; // all dark out of reset
        end else begin
            lamps <= pattern;
        end
    end

    // ####################
    // checks

    // a sweeping side shows a nonzero thermometer code, brake or not
    a_sweep_is_thermometer : assert property (
        @(posedge clk) disable iff (rst)
        (state != seq_pkg::SEQ_IDLE) |=>
            ((lamps & lamp_pkg::lamp_t'(lamps + 1'b1)) == lamp_pkg::LAMPS_OFF)
            && (lamps != lamp_pkg::LAMPS_OFF)
    ) else $error("sweep pattern is not a thermometer code");

endmodule

//--- design/turn_sequencer.sv
module turn_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                step_tick,
    input  logic                request,
    output seq_pkg::seq_state_t state
);

    // next sweep state, only taken when step_tick is high
    seq_pkg::seq_state_t state_next;

    // ####################
    // next state

    always_comb begin
        state_next = state; // hold by default
        case (state)
            seq_pkg::SEQ_IDLE: begin
                // request is only looked at here, a drop mid sweep is ignored
                if (request) begin
                    state_next = seq_pkg::SEQ_ONE;
                end
            end
            seq_pkg::SEQ_ONE:   state_next = seq_pkg::SEQ_TWO;
            seq_pkg::SEQ_TWO:   state_next = seq_pkg::SEQ_THREE;
            seq_pkg::SEQ_THREE: state_next = seq_pkg::SEQ_IDLE; // back to dark
            default:            state_next = seq_pkg::SEQ_IDLE;
        endcase
    end

    // ####################
    // state register

    // advances once per step tick, one cycle after the tick edge
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_pkg::SEQ_IDLE;
        end else if (step_tick) begin
            state <= state_next;
        end
    end

    // a held request leaves SEQ_THREE for idle and is taken on the
    // following tick, so repeats have one dark step between sweeps

    // ####################
    // checks

    // the sweep only moves on the shared tick, which keeps both sides
    // in phase during a hazard flash
    a_state_moves_on_tick : assert property (
        @(posedge clk) disable iff (rst)
        !step_tick |=> $stable(state)
    ) else $error("sequencer state changed without step_tick");

    // no spurious start, idle is only left on a request
    a_idle_needs_request : assert property (
        @(posedge clk) disable iff (rst)
        (state == seq_pkg::SEQ_IDLE && !request) |=> (state == seq_pkg::SEQ_IDLE)
    ) else $error("sequencer left idle without a request");

endmodule

//--- design/tick_timer.sv
module tick_timer (
    input  logic clk,
    input  logic rst,
    output logic step_tick
);

    // free running step counter, wraps every 2**TICK_BITS clocks
    logic [seq_pkg::TICK_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + 1'b1; // wrap is intended
        end
    end

    // all-ones decode, one cycle wide
    // first tick lands in the fourth cycle after rst drops
    assign step_tick = &count;

    // ####################
    // checks

    // the tick is a clock enable pulse, never a level
    // sequencers would skip states if it stretched
    a_tick_single_cycle : assert property (
        @(posedge clk) disable iff (rst)
        step_tick |=> !step_tick
    ) else $error("step_tick high on two consecutive cycles");

endmodule

//--- design/lamp_pkg.sv
package lamp_pkg;

    // ####################
    // lamp layout

    // three lamps per side, same as the classic rear cluster
    localparam int LAMP_COUNT = 3;

    // bit 0 is the inner lamp, bit 2 the outer one
    typedef logic [LAMP_COUNT-1:0] lamp_t;

    // ####################
    // fixed patterns

    localparam lamp_t LAMPS_OFF = '0; // side dark
    localparam lamp_t LAMPS_ON  = '1; // brake on an idle side

endpackage

//--- design/seq_pkg.sv
package seq_pkg;

    // ####################
    // step timing

    // tick counter width, the period is 2**TICK_BITS clocks
    // kept at 2 so a full sweep fits in a short simulation
    localparam int TICK_BITS = 2;

    // ####################
    // sweep state

    // one state per lit-lamp count, encoding matches the lamp count
    // so the encoder can build the pattern straight from the value
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0, // dark, waiting for a request at a tick
        SEQ_ONE   = 2'd1, // inner lamp only
        SEQ_TWO   = 2'd2, // inner and middle
        SEQ_THREE = 2'd3  // all three, goes back to idle next tick
    } seq_state_t;

endpackage
